// File: src/mips_defines.svh
// MIPS core constants
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

`define MIPS_XLEN      32  // Data and address width
`define MIPS_REG_BITS  5   // Register index width

`define MIPS_OP_RTYPE  6'b000000
`define MIPS_OP_LW     6'b100011
`define MIPS_OP_SW     6'b101011
`define MIPS_OP_BEQ    6'b000100
`define MIPS_OP_ADDI   6'b001000

`define MIPS_FN_ADD    6'b100000
`define MIPS_FN_SUB    6'b100010
`define MIPS_FN_AND    6'b100100
`define MIPS_FN_OR     6'b100101
`define MIPS_FN_SLT    6'b101010

`endif

// File: src/mips_pkg.sv
// MIPS core types
`include "mips_defines.svh"

package mips_pkg;

    typedef logic [`MIPS_XLEN-1:0]     word_t;
    typedef logic [`MIPS_REG_BITS-1:0] reg_idx_t;
    typedef logic [5:0]                opcode_t;
    typedef logic [5:0]                funct_t;
    typedef logic [15:0]               imm_t;

    // ALU operation encodings
    typedef enum logic [2:0] {
        ALU_AND = 3'b000,
        ALU_OR  = 3'b001,
        ALU_ADD = 3'b010,
        ALU_NOP = 3'b101,  // Result is forced to zero
        ALU_SUB = 3'b110,
        ALU_SLT = 3'b111
    } alu_op_e;

    // Operand source selected by the forwarding logic
    typedef enum logic [1:0] {
        FWD_REG = 2'b00,
        FWD_WB  = 2'b01,
        FWD_MEM = 2'b10
    } fwd_sel_e;

endpackage

// File: src/hazard_if.sv
// Hazard unit interface
interface hazard_if;

    mips_pkg::reg_idx_t rs_d;
    mips_pkg::reg_idx_t rt_d;
    logic               branch_d;
    mips_pkg::reg_idx_t rs_e;
    mips_pkg::reg_idx_t rt_e;
    logic               memtoreg_e;
    logic               regwrite_e;
    mips_pkg::reg_idx_t writereg_e;
    logic               memtoreg_m;
    logic               regwrite_m;
    mips_pkg::reg_idx_t writereg_m;
    logic               regwrite_w;
    mips_pkg::reg_idx_t writereg_w;
    logic               stall;
    mips_pkg::fwd_sel_e fwd_a_d, fwd_b_d;  // Decode only uses FWD_REG and FWD_MEM
    mips_pkg::fwd_sel_e fwd_a_e, fwd_b_e;

    modport control (input rs_d, rt_d, branch_d, rs_e, rt_e, memtoreg_e, regwrite_e,
                     writereg_e, memtoreg_m, regwrite_m, writereg_m, regwrite_w,
                     writereg_w, output stall, fwd_a_d, fwd_b_d, fwd_a_e, fwd_b_e);
    modport decode (output rs_d, rt_d, branch_d, input stall, fwd_a_d, fwd_b_d);
    modport execute (input rs_d, rt_d, stall, fwd_a_e, fwd_b_e,
                     output rs_e, rt_e, memtoreg_e, regwrite_e, writereg_e,
                     memtoreg_m, regwrite_m, writereg_m);
    modport writeback (input memtoreg_m, regwrite_m, writereg_m,
                       output regwrite_w, writereg_w);

endinterface

// File: src/hazard_unit.sv
// Pipeline hazard control
module hazard_unit (
    hazard_if.control hz
);

    logic lw_stall;
    logic branch_stall;

    // True when dst is a nonzero register read by the instruction in decode
    function automatic logic hits_decode(input mips_pkg::reg_idx_t dst,
                                         input mips_pkg::reg_idx_t rs,
                                         input mips_pkg::reg_idx_t rt);
        return (dst != '0) && ((dst == rs) || (dst == rt));
    endfunction

    function automatic mips_pkg::fwd_sel_e sel_d(input mips_pkg::reg_idx_t src);
        if (src != '0 && hz.regwrite_m && src == hz.writereg_m)
            return mips_pkg::FWD_MEM;
        return mips_pkg::FWD_REG;
    endfunction

    // Memory stage wins since it holds the newer value
    function automatic mips_pkg::fwd_sel_e sel_e(input mips_pkg::reg_idx_t src);
        if (src != '0 && hz.regwrite_m && src == hz.writereg_m)
            return mips_pkg::FWD_MEM;
        if (src != '0 && hz.regwrite_w && src == hz.writereg_w)
            return mips_pkg::FWD_WB;
        return mips_pkg::FWD_REG;
    endfunction

    assign hz.fwd_a_d = sel_d(hz.rs_d);
    assign hz.fwd_b_d = sel_d(hz.rt_d);
    assign hz.fwd_a_e = sel_e(hz.rs_e);
    assign hz.fwd_b_e = sel_e(hz.rt_e);

    assign lw_stall = hz.memtoreg_e && hits_decode(hz.writereg_e, hz.rs_d, hz.rt_d);

    // The branch compares in decode, so an ALU result still in execute is too late,
    // and so is load data still in the memory stage
    assign branch_stall = hz.branch_d &&
        ((hz.regwrite_e && hits_decode(hz.writereg_e, hz.rs_d, hz.rt_d)) ||
         (hz.memtoreg_m && hits_decode(hz.writereg_m, hz.rs_d, hz.rt_d)));

    assign hz.stall = lw_stall || branch_stall;

endmodule

// File: src/reg_file.sv
// Register file
module reg_file (
    input  logic               clk,
    input  logic               rst,
    input  mips_pkg::reg_idx_t ra1,
    input  mips_pkg::reg_idx_t ra2,
    input  logic               we,
    input  mips_pkg::reg_idx_t wa,
    input  mips_pkg::word_t    wd,
    output mips_pkg::word_t    rd1,
    output mips_pkg::word_t    rd2
);

    mips_pkg::word_t regs [1:31];  // Register zero has no storage

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) regs[i] <= '0;
        end else if (we && wa != '0) begin
            regs[wa] <= wd;
        end
    end

    // A read of the register being written sees the new value
    assign rd1 = (ra1 == '0) ? '0 : (we && wa == ra1) ? wd : regs[ra1];
    assign rd2 = (ra2 == '0) ? '0 : (we && wa == ra2) ? wd : regs[ra2];

endmodule

// File: src/fetch_decode.sv
// Fetch and decode stages
`include "mips_defines.svh"

module fetch_decode (
    input  logic               clk,
    input  logic               rst,
    input  mips_pkg::word_t    instr,
    output mips_pkg::word_t    pc,
    hazard_if.decode           hz,
    input  mips_pkg::word_t    aluout_m,
    output mips_pkg::reg_idx_t rf_ra1,
    output mips_pkg::reg_idx_t rf_ra2,
    input  mips_pkg::word_t    rf_rd1,
    input  mips_pkg::word_t    rf_rd2,
    output mips_pkg::word_t    rd1_d,
    output mips_pkg::word_t    rd2_d,
    output mips_pkg::word_t    signimm_d,
    output mips_pkg::reg_idx_t rd_d,
    output logic               regwrite_d,
    output logic               memtoreg_d,
    output logic               memwrite_d,
    output logic               alusrc_d,
    output logic               regdst_d,
    output mips_pkg::alu_op_e  aluop_d
);

    mips_pkg::word_t    instr_d;
    mips_pkg::word_t    pcplus4_d;
    logic               valid_d;
    mips_pkg::opcode_t  opcode_d;
    mips_pkg::funct_t   funct_d;
    mips_pkg::imm_t     imm_d;
    mips_pkg::word_t    pcbranch_d;
    logic               branch_d;
    logic               pcsrc_d;

    assign pcsrc_d = branch_d && (rd1_d == rd2_d) && !hz.stall;  // Taken beq

    always_ff @(posedge clk) begin
        if (rst) pc <= '0;
        else if (!hz.stall) pc <= pcsrc_d ? pcbranch_d : pc + 32'd4;
    end

    always_ff @(posedge clk) begin
        if (rst) valid_d <= 1'b0;
        else if (!hz.stall) valid_d <= !pcsrc_d;  // Squash the instruction behind a branch
    end

    always_ff @(posedge clk) begin
        if (!hz.stall) begin
            instr_d   <= instr;
            pcplus4_d <= pc + 32'd4;
        end
    end

    assign opcode_d   = instr_d[31:26];
    assign funct_d    = instr_d[5:0];
    assign imm_d      = instr_d[15:0];
    assign rd_d       = instr_d[15:11];
    assign signimm_d  = {{16{imm_d[15]}}, imm_d};
    assign pcbranch_d = pcplus4_d + {signimm_d[29:0], 2'b00};

    // Invalid slots read r0 so they never match a hazard
    assign rf_ra1   = valid_d ? instr_d[25:21] : '0;
    assign rf_ra2   = valid_d ? instr_d[20:16] : '0;
    assign hz.rs_d  = rf_ra1;
    assign hz.rt_d  = rf_ra2;
    assign hz.branch_d = branch_d;

    assign rd1_d = (hz.fwd_a_d == mips_pkg::FWD_MEM) ? aluout_m : rf_rd1;
    assign rd2_d = (hz.fwd_b_d == mips_pkg::FWD_MEM) ? aluout_m : rf_rd2;

    always_comb begin
        regwrite_d = 1'b0;
        memtoreg_d = 1'b0;
        memwrite_d = 1'b0;
        alusrc_d   = 1'b0;
        regdst_d   = 1'b0;
        branch_d   = 1'b0;
        aluop_d    = mips_pkg::ALU_NOP;
        if (valid_d) begin
            case (opcode_d)
                `MIPS_OP_RTYPE: begin
                    regwrite_d = 1'b1;
                    regdst_d   = 1'b1;
                    case (funct_d)
                        `MIPS_FN_ADD: aluop_d = mips_pkg::ALU_ADD;
                        `MIPS_FN_SUB: aluop_d = mips_pkg::ALU_SUB;
                        `MIPS_FN_AND: aluop_d = mips_pkg::ALU_AND;
                        `MIPS_FN_OR:  aluop_d = mips_pkg::ALU_OR;
                        `MIPS_FN_SLT: aluop_d = mips_pkg::ALU_SLT;
                        default:      aluop_d = mips_pkg::ALU_NOP;
                    endcase
                end
                `MIPS_OP_LW: begin
                    regwrite_d = 1'b1;
                    memtoreg_d = 1'b1;
                    alusrc_d   = 1'b1;
                    aluop_d    = mips_pkg::ALU_ADD;  // Address is base plus offset
                end
                `MIPS_OP_SW: begin
                    memwrite_d = 1'b1;
                    alusrc_d   = 1'b1;
                    aluop_d    = mips_pkg::ALU_ADD;
                end
                `MIPS_OP_ADDI: begin
                    regwrite_d = 1'b1;
                    alusrc_d   = 1'b1;
                    aluop_d    = mips_pkg::ALU_ADD;
                end
                `MIPS_OP_BEQ: branch_d = 1'b1;
                default: branch_d = 1'b0;
            endcase
        end
    end

endmodule

// File: src/execute_stage.sv
// Execute stage
module execute_stage (
    input  logic               clk,
    input  logic               rst,
    input  mips_pkg::word_t    rd1_d,
    input  mips_pkg::word_t    rd2_d,
    input  mips_pkg::word_t    signimm_d,
    input  mips_pkg::reg_idx_t rd_d,
    input  logic               regwrite_d,
    input  logic               memtoreg_d,
    input  logic               memwrite_d,
    input  logic               alusrc_d,
    input  logic               regdst_d,
    input  mips_pkg::alu_op_e  aluop_d,
    hazard_if.execute          hz,
    input  mips_pkg::word_t    result_w,
    output mips_pkg::word_t    aluout_m,
    output mips_pkg::word_t    writedata_m,
    output logic               memwrite_m
);

    logic               regwrite_e, memtoreg_e, memwrite_e, alusrc_e, regdst_e;
    mips_pkg::alu_op_e  aluop_e;
    mips_pkg::reg_idx_t rs_e, rt_e, rd_e, writereg_e, writereg_m;
    mips_pkg::word_t    rd1_e, rd2_e, signimm_e;
    mips_pkg::word_t    srca_e, writedata_e, srcb_e, aluout_e;
    logic               regwrite_m, memtoreg_m;

    function automatic mips_pkg::word_t pick(input mips_pkg::fwd_sel_e sel,
                                             input mips_pkg::word_t reg_val,
                                             input mips_pkg::word_t wb_val,
                                             input mips_pkg::word_t mem_val);
        case (sel)
            mips_pkg::FWD_MEM: return mem_val;
            mips_pkg::FWD_WB:  return wb_val;
            default:           return reg_val;
        endcase
    endfunction

    // A stall inserts a bubble here while decode holds
    always_ff @(posedge clk) begin
        if (rst || hz.stall) begin
            {regwrite_e, memtoreg_e, memwrite_e, alusrc_e, regdst_e} <= '0;
            aluop_e <= mips_pkg::ALU_NOP;
            {rs_e, rt_e, rd_e} <= '0;
        end else begin
            {regwrite_e, memtoreg_e, memwrite_e} <= {regwrite_d, memtoreg_d, memwrite_d};
            {alusrc_e, regdst_e} <= {alusrc_d, regdst_d};
            aluop_e <= aluop_d;
            {rs_e, rt_e, rd_e} <= {hz.rs_d, hz.rt_d, rd_d};
        end
    end

    always_ff @(posedge clk) begin
        rd1_e     <= rd1_d;
        rd2_e     <= rd2_d;
        signimm_e <= signimm_d;
    end

    assign srca_e      = pick(hz.fwd_a_e, rd1_e, result_w, aluout_m);
    assign writedata_e = pick(hz.fwd_b_e, rd2_e, result_w, aluout_m);
    assign srcb_e      = alusrc_e ? signimm_e : writedata_e;
    assign writereg_e  = regdst_e ? rd_e : rt_e;

    always_comb begin
        case (aluop_e)
            mips_pkg::ALU_ADD: aluout_e = srca_e + srcb_e;
            mips_pkg::ALU_SUB: aluout_e = srca_e - srcb_e;
            mips_pkg::ALU_AND: aluout_e = srca_e & srcb_e;
            mips_pkg::ALU_OR:  aluout_e = srca_e | srcb_e;
            mips_pkg::ALU_SLT: aluout_e = {31'd0, $signed(srca_e) < $signed(srcb_e)};
            default:           aluout_e = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            {regwrite_m, memtoreg_m, memwrite_m} <= '0;
            writereg_m <= '0;
        end else begin
            {regwrite_m, memtoreg_m, memwrite_m} <= {regwrite_e, memtoreg_e, memwrite_e};
            writereg_m <= writereg_e;
        end
    end

    always_ff @(posedge clk) begin
        aluout_m    <= aluout_e;
        writedata_m <= writedata_e;
    end

    assign hz.rs_e       = rs_e;
    assign hz.rt_e       = rt_e;
    assign hz.memtoreg_e = memtoreg_e;
    assign hz.regwrite_e = regwrite_e;
    assign hz.writereg_e = writereg_e;
    assign hz.memtoreg_m = memtoreg_m;
    assign hz.regwrite_m = regwrite_m;
    assign hz.writereg_m = writereg_m;

endmodule

// File: src/writeback_stage.sv
// Writeback stage
module writeback_stage (
    input  logic               clk,
    input  logic               rst,
    hazard_if.writeback        hz,
    input  mips_pkg::word_t    aluout_m,
    input  mips_pkg::word_t    readdata,
    output mips_pkg::word_t    result_w,
    output logic               rf_we,
    output mips_pkg::reg_idx_t rf_wa
);

    logic               regwrite_w;
    logic               memtoreg_w;
    mips_pkg::reg_idx_t writereg_w;
    mips_pkg::word_t    aluout_w;
    mips_pkg::word_t    readdata_w;

    always_ff @(posedge clk) begin
        if (rst) begin
            regwrite_w <= 1'b0;
            memtoreg_w <= 1'b0;
            writereg_w <= '0;
        end else begin
            regwrite_w <= hz.regwrite_m;
            memtoreg_w <= hz.memtoreg_m;
            writereg_w <= hz.writereg_m;
        end
    end

    always_ff @(posedge clk) begin
        aluout_w   <= aluout_m;
        readdata_w <= readdata;  // Load data arrives in the memory stage
    end

    assign result_w      = memtoreg_w ? readdata_w : aluout_w;
    assign rf_we         = regwrite_w;
    assign rf_wa         = writereg_w;
    assign hz.regwrite_w = regwrite_w;
    assign hz.writereg_w = writereg_w;

endmodule

// File: src/mips_core.sv
// Pipelined MIPS core
module mips_core (
    input  logic            clk,
    input  logic            rst,
    output mips_pkg::word_t pc,
    input  mips_pkg::word_t instr,
    output mips_pkg::word_t aluout,
    output mips_pkg::word_t writedata,
    output logic            memwrite,
    input  mips_pkg::word_t readdata
);

    mips_pkg::word_t    rd1_d, rd2_d, signimm_d;
    mips_pkg::reg_idx_t rd_d;
    logic               regwrite_d, memtoreg_d, memwrite_d, alusrc_d, regdst_d;
    mips_pkg::alu_op_e  aluop_d;
    mips_pkg::reg_idx_t rf_ra1, rf_ra2, rf_wa;
    mips_pkg::word_t    rf_rd1, rf_rd2;
    logic               rf_we;
    mips_pkg::word_t    aluout_m, writedata_m, result_w;
    logic               memwrite_m;

    hazard_if hz ();

    hazard_unit u_hazard (.hz(hz.control));

    reg_file u_rf (
        .clk(clk), .rst(rst), .ra1(rf_ra1), .ra2(rf_ra2),
        .we(rf_we), .wa(rf_wa), .wd(result_w), .rd1(rf_rd1), .rd2(rf_rd2)
    );

    fetch_decode u_fd (
        .clk(clk), .rst(rst), .instr(instr), .pc(pc), .hz(hz.decode),
        .aluout_m(aluout_m), .rf_ra1(rf_ra1), .rf_ra2(rf_ra2),
        .rf_rd1(rf_rd1), .rf_rd2(rf_rd2),
        .rd1_d(rd1_d), .rd2_d(rd2_d), .signimm_d(signimm_d), .rd_d(rd_d),
        .regwrite_d(regwrite_d), .memtoreg_d(memtoreg_d), .memwrite_d(memwrite_d),
        .alusrc_d(alusrc_d), .regdst_d(regdst_d), .aluop_d(aluop_d)
    );

    execute_stage u_ex (
        .clk(clk), .rst(rst),
        .rd1_d(rd1_d), .rd2_d(rd2_d), .signimm_d(signimm_d), .rd_d(rd_d),
        .regwrite_d(regwrite_d), .memtoreg_d(memtoreg_d), .memwrite_d(memwrite_d),
        .alusrc_d(alusrc_d), .regdst_d(regdst_d), .aluop_d(aluop_d),
        .hz(hz.execute), .result_w(result_w),
        .aluout_m(aluout_m), .writedata_m(writedata_m), .memwrite_m(memwrite_m)
    );

    writeback_stage u_wb (
        .clk(clk), .rst(rst), .hz(hz.writeback),
        .aluout_m(aluout_m), .readdata(readdata),
        .result_w(result_w), .rf_we(rf_we), .rf_wa(rf_wa)
    );

    // Data memory sees the memory stage directly
    assign aluout    = aluout_m;
    assign writedata = writedata_m;
    assign memwrite  = memwrite_m;

endmodule

// File: sim/tb_mem.sv
// Instruction and data memory model
module tb_mem (
    input  logic            clk,
    input  mips_pkg::word_t pc,
    output mips_pkg::word_t instr,
    input  mips_pkg::word_t addr,
    input  mips_pkg::word_t wdata,
    input  logic            we,
    output mips_pkg::word_t rdata
);
    timeunit 1ns;
    timeprecision 1ps;

    mips_pkg::word_t rom [128];
    mips_pkg::word_t ram [64];
    mips_pkg::word_t instr_q = '0;
    mips_pkg::word_t rdata_q = '0;

    // Unused words hold an undefined opcode tagged with their own index
    initial begin
        for (int i = 0; i < 128; i++) rom[i] = {6'b111111, 26'(i)};
        for (int i = 0; i < 64; i++) ram[i] = 32'h6b8b_4567 ^ (32'(i) * 32'h9e37_79b9);
    end

    always @(posedge clk) begin
        if (we) ram[addr[7:2]] <= wdata;  // Store lands at the edge that ends the memory stage
    end

    // Outputs change on the falling edge, half a cycle after pc and addr settle
    always @(negedge clk) begin
        instr_q <= rom[pc[8:2]];
        rdata_q <= ram[addr[7:2]];
    end

    assign instr = instr_q;
    assign rdata = rdata_q;

endmodule

// File: sim/tb_mips.sv
// MIPS core testbench
`include "mips_defines.svh"

module tb_mips;
    timeunit 1ns;
    timeprecision 1ps;

    logic            clk;
    logic            rst;
    mips_pkg::word_t pc, instr, aluout, writedata, readdata;
    logic            memwrite;

    mips_pkg::word_t prog [$];
    mips_pkg::word_t exp_addr [$];
    mips_pkg::word_t exp_data [$];
    int unsigned     seen = 0;
    int unsigned     cycles = 0;
    int unsigned     cycle_limit;
    logic [31:0]     rng_state;

    tb_mem mem (.clk(clk), .pc(pc), .instr(instr), .addr(aluout), .wdata(writedata),
                .we(memwrite), .rdata(readdata));

    mips_core uut (.clk(clk), .rst(rst), .pc(pc), .instr(instr), .aluout(aluout),
                   .writedata(writedata), .memwrite(memwrite), .readdata(readdata));

    always #5 clk = ~clk;

    task automatic fail_with(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic value_error(input string name, input mips_pkg::word_t got,
                               input mips_pkg::word_t exp);
        fail_with($sformatf("** Error: %s = 0x%08h, expected 0x%08h", name, got, exp));
    endtask

    function automatic logic [31:0] next_random();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic int random_imm();
        return int'(next_random() >> 16);  // Upper bits of an LCG are the better ones
    endfunction

    function automatic mips_pkg::word_t encode_r(input mips_pkg::funct_t fn,
                                                 input int rd, input int rs, input int rt);
        return {`MIPS_OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
    endfunction

    function automatic mips_pkg::word_t encode_i(input mips_pkg::opcode_t op,
                                                 input int rt, input int rs, input int imm);
        return {op, 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    task automatic emit(input mips_pkg::word_t w);
        prog.push_back(w);
    endtask

    task automatic build_program();
        int base;
        // Each round loads fresh operands and stores every ALU result back-to-back
        for (int r = 0; r < 4; r++) begin
            base = r * 32;
            for (int k = 1; k <= 4; k++) emit(encode_i(`MIPS_OP_ADDI, k, 0, random_imm()));
            emit(encode_r(`MIPS_FN_ADD, 5, 1, 2));
            emit(encode_i(`MIPS_OP_SW, 5, 0, base));       // r5 forwarded from memory
            emit(encode_r(`MIPS_FN_SUB, 6, 1, 2));
            emit(encode_r(`MIPS_FN_AND, 7, 5, 6));         // Operands from register file and memory
            emit(encode_i(`MIPS_OP_SW, 6, 0, base + 4));
            emit(encode_i(`MIPS_OP_SW, 7, 0, base + 8));
            emit(encode_r(`MIPS_FN_OR, 8, 3, 4));
            emit(encode_r(`MIPS_FN_SLT, 9, 3, 4));
            emit(encode_r(`MIPS_FN_SLT, 10, 4, 3));
            emit(encode_i(`MIPS_OP_ADDI, 11, 8, random_imm()));
            emit(encode_i(`MIPS_OP_SW, 8, 0, base + 12));
            emit(encode_i(`MIPS_OP_SW, 9, 0, base + 16));
            emit(encode_i(`MIPS_OP_SW, 10, 0, base + 20));
            emit(encode_i(`MIPS_OP_SW, 11, 0, base + 24));
        end
        // Load-use pairs
        emit(encode_i(`MIPS_OP_LW, 12, 0, 0));
        emit(encode_r(`MIPS_FN_ADD, 13, 12, 1));
        emit(encode_i(`MIPS_OP_SW, 13, 0, 'h80));
        emit(encode_i(`MIPS_OP_LW, 14, 0, 4));
        emit(encode_i(`MIPS_OP_SW, 14, 0, 'h84));
        // Taken beq on a fresh operand, then a not-taken one
        emit(encode_i(`MIPS_OP_ADDI, 16, 0, 7));
        emit(encode_i(`MIPS_OP_ADDI, 17, 0, 7));
        emit(encode_i(`MIPS_OP_BEQ, 17, 16, 1));
        emit(encode_i(`MIPS_OP_SW, 1, 0, 'h88));
        emit(encode_i(`MIPS_OP_SW, 2, 0, 'h8c));
        emit(encode_i(`MIPS_OP_ADDI, 18, 0, 9));
        emit(encode_i(`MIPS_OP_BEQ, 16, 18, 1));
        emit(encode_i(`MIPS_OP_SW, 3, 0, 'h90));
        emit(encode_i(`MIPS_OP_SW, 4, 0, 'h94));
        emit(encode_i(`MIPS_OP_LW, 19, 0, 'h8c));
        emit(encode_i(`MIPS_OP_BEQ, 2, 19, 1));       // Branch operand still being loaded
        emit(encode_i(`MIPS_OP_SW, 4, 0, 'h98));
        emit(encode_i(`MIPS_OP_SW, 1, 0, 'h9c));
        // Writes to r0 are dropped
        emit(encode_i(`MIPS_OP_ADDI, 0, 0, random_imm() | 1));
        emit(encode_i(`MIPS_OP_SW, 0, 0, 'ha0));
        emit(encode_r(`MIPS_FN_ADD, 0, 1, 2));
        emit(encode_i(`MIPS_OP_SW, 0, 0, 'ha4));
        emit(encode_i(`MIPS_OP_BEQ, 0, 0, -1));
    endtask

    // Executes the program one instruction at a time and records the stores
    task automatic run_model();
        mips_pkg::word_t regs [32];
        mips_pkg::word_t dmem [mips_pkg::word_t];
        mips_pkg::word_t w, a, b, simm, addr;
        int              idx;
        int              steps;
        logic            done;
        for (int i = 0; i < 32; i++) regs[i] = '0;
        idx = 0;
        steps = 0;
        done = 1'b0;
        while (!done) begin
            if (idx < 0 || idx >= prog.size() || steps > 10000)
                fail_with("reference model ran off the end of the program");
            w = prog[idx];
            a = regs[w[25:21]];
            b = regs[w[20:16]];
            simm = {{16{w[15]}}, w[15:0]};
            addr = a + simm;
            idx++;
            steps++;
            case (w[31:26])
                `MIPS_OP_RTYPE: begin
                    case (w[5:0])
                        `MIPS_FN_ADD: regs[w[15:11]] = a + b;
                        `MIPS_FN_SUB: regs[w[15:11]] = a - b;
                        `MIPS_FN_AND: regs[w[15:11]] = a & b;
                        `MIPS_FN_OR:  regs[w[15:11]] = a | b;
                        `MIPS_FN_SLT: regs[w[15:11]] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: fail_with("reference model met an unknown funct code");
                    endcase
                end
                `MIPS_OP_ADDI: regs[w[20:16]] = addr;
                `MIPS_OP_LW: begin
                    if (!dmem.exists(addr))
                        fail_with("program loads from an address it never stored");
                    regs[w[20:16]] = dmem[addr];
                end
                `MIPS_OP_SW: begin
                    dmem[addr] = b;
                    exp_addr.push_back(addr);
                    exp_data.push_back(b);
                end
                `MIPS_OP_BEQ: begin
                    if (a == b && $signed(simm) == -1) done = 1'b1;  // Final self-loop
                    else if (a == b) idx = idx + $signed(simm);
                end
                default: fail_with("reference model met an unknown opcode");
            endcase
            regs[0] = '0;
        end
    endtask

    task automatic load_rom();
        for (int i = 0; i < prog.size(); i++) mem.rom[i] = prog[i];
    endtask

    // Stores are checked half a cycle before the edge that writes them
    always @(negedge clk) begin
        if (rst) begin
            assert (memwrite === 1'b0) else fail_with("memwrite was high during reset");
            assert (pc === '0) else value_error("pc", pc, '0);
        end else begin
            // Fetch never runs past the word after the final self-loop
            assert (pc[1:0] === 2'b00 && pc <= 32'(4 * prog.size()))
                else fail_with($sformatf("pc 0x%08h left the program", pc));
            if (memwrite === 1'b1) begin
                assert (seen < exp_addr.size())
                    else fail_with("a store arrived after the last expected store");
                assert (aluout === exp_addr[seen])
                    else value_error("aluout", aluout, exp_addr[seen]);
                assert (writedata === exp_data[seen])
                    else value_error("writedata", writedata, exp_data[seen]);
                seen++;
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        assert (cycles < cycle_limit)
            else fail_with($sformatf("run timed out after %0d cycles", cycles));
    end

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        rng_state = 32'h2fc5_5e89;
        build_program();
        run_model();
        cycle_limit = 20 * prog.size() + 100;
        #1;
        load_rom();  // After the memory model has applied its fill pattern
        repeat (8) @(negedge clk);
        rst = 1'b0;
        while (seen < exp_addr.size()) @(posedge clk);
        repeat (20) @(posedge clk);  // Any extra store shows up here
        $display("sim passed");
        $finish;
    end

endmodule

// File: src.f
+incdir+src
src/mips_pkg.sv
src/hazard_if.sv
src/hazard_unit.sv
src/reg_file.sv
src/fetch_decode.sv
src/execute_stage.sv
src/writeback_stage.sv
src/mips_core.sv
sim/tb_mem.sv
sim/tb_mips.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_mips
FILELIST  = src.f
OBJDIR    = obj_dir
PASS_MSG  = sim passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(OBJDIR)
